// ==== source/commitPkg.sv ====
package commitPkg;

  // machine word and register file shape
  localparam int dataWidth = 64;
  localparam int regCount = 32;
  localparam int regAddrWidth = $clog2(regCount);
  localparam int cmdWidth = 3;

  // flag word holds N, Z, V and C, carry sits in bit 3
  localparam int flagWidth = 4;
  localparam int flagN = 0;
  localparam int flagZ = 1;
  localparam int flagV = 2;

  // command codes, bit 0 of a conditional branch is its predicted direction
  localparam logic [cmdWidth-1:0] cmdAlu = 3'd0;
  localparam logic [cmdWidth-1:0] cmdStore = 3'd1;
  localparam logic [cmdWidth-1:0] cmdBcondNot = 3'd2;
  localparam logic [cmdWidth-1:0] cmdBcondTaken = 3'd3;
  localparam logic [cmdWidth-1:0] cmdCbzNot = 3'd4;
  localparam logic [cmdWidth-1:0] cmdCbzTaken = 3'd5;
  localparam logic [cmdWidth-1:0] cmdBr = 3'd6;
  localparam logic [cmdWidth-1:0] cmdBl = 3'd7;

  // branch condition codes, anything else decodes as LE
  localparam logic [regAddrWidth-1:0] condEq = 5'b00000;
  localparam logic [regAddrWidth-1:0] condNe = 5'b00001;
  localparam logic [regAddrWidth-1:0] condGe = 5'b01010;
  localparam logic [regAddrWidth-1:0] condLt = 5'b01011;
  localparam logic [regAddrWidth-1:0] condGt = 5'b01100;

  // destination field of an entry
  // register writers and CBZ/BR read it as an index, B.cond as a condition
  typedef union packed {
    logic [regAddrWidth-1:0] regIdx;
    logic [regAddrWidth-1:0] cond;
  } robDest_u;

  // only ALU ops and BL leave a result in the register file
  function automatic logic writesReg(input logic [cmdWidth-1:0] cmd);
    return (cmd == cmdAlu) || (cmd == cmdBl);
  endfunction

endpackage

// ==== source/commitIfs.sv ====
`timescale 1ns/1ps

interface robCommitIf #(
  parameter int robSize = 32
);
  localparam int tagWidth = $clog2(robSize);

  logic headValid;
  logic [tagWidth-1:0] headTag;
  logic [commitPkg::cmdWidth-1:0] headCmd;
  commitPkg::robDest_u headDest;
  logic headFlagValid;
  logic [commitPkg::flagWidth-1:0] headFlags;
  logic [commitPkg::dataWidth-1:0] headData;
  logic retire;
  logic flushDone;
  // high from flush request until the ack drops again
  logic flushBusy;

  modport rob (
    output headValid, headTag, headCmd, headDest, headFlagValid, headFlags, headData,
    input retire, flushDone, flushBusy
  );
  modport commit (
    input headValid, headTag, headCmd, headDest, headFlagValid, headFlags, headData,
    output retire, flushDone, flushBusy
  );
endinterface

interface mapCommitIf #(
  parameter int robSize = 32
);
  localparam int tagWidth = $clog2(robSize);

  logic [commitPkg::regAddrWidth-1:0] readReg;
  logic [tagWidth-1:0] readTag;
  logic readPending;
  logic releaseEn;
  logic [tagWidth-1:0] releaseTag;
  logic flushAll;

  modport map (input readReg, releaseEn, releaseTag, flushAll, output readTag, readPending);
  modport commit (output readReg, releaseEn, releaseTag, flushAll, input readTag, readPending);
endinterface

interface regPortIf;
  logic writeEn;
  logic [commitPkg::regAddrWidth-1:0] writeAddr;
  logic [commitPkg::dataWidth-1:0] writeData;
  logic [commitPkg::regAddrWidth-1:0] readAddr;
  logic [commitPkg::dataWidth-1:0] readData;

  modport rf (input writeEn, writeAddr, writeData, readAddr, output readData);
  modport commit (output writeEn, writeAddr, writeData, readAddr, input readData);
endinterface

// ==== source/reorderBuffer.sv ====
`timescale 1ns/1ps

module reorderBuffer #(
  parameter int robSize = 32,
  localparam int tagWidth = $clog2(robSize)
) (
  input  logic                               clk_i,
  input  logic                               arstN_i,
  input  logic                               dispatchReq_i,
  input  logic [commitPkg::cmdWidth-1:0]     dispatchCmd_i,
  input  commitPkg::robDest_u                dispatchDest_i,
  output logic                               dispatchAck_o,
  output logic [tagWidth-1:0]                dispatchTag_o,
  output logic [tagWidth-1:0]                tailTag_o,
  output logic                               dispatchWrites_o,
  input  logic                               completeValid_i,
  input  logic [tagWidth-1:0]                completeTag_i,
  input  logic                               completeFlagValid_i,
  input  logic [commitPkg::flagWidth-1:0]    completeFlags_i,
  input  logic [commitPkg::dataWidth-1:0]    completeData_i,
  robCommitIf.rob                            rob
);

  localparam int countWidth = $clog2(robSize + 1);

  // per-entry payload
  logic [commitPkg::cmdWidth-1:0] cmdMem [robSize];
  commitPkg::robDest_u destMem [robSize];
  logic flagValidMem [robSize];
  logic [commitPkg::flagWidth-1:0] flagsMem [robSize];
  logic [commitPkg::dataWidth-1:0] dataMem [robSize];
  // result arrived for this entry
  logic [robSize-1:0] doneMem;

  logic [tagWidth-1:0] head;
  logic [tagWidth-1:0] tail;
  logic [countWidth-1:0] count;
  logic full;
  logic accept;

  function automatic logic [tagWidth-1:0] nextPtr(input logic [tagWidth-1:0] ptr);
    return (ptr == tagWidth'(robSize - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full = (count == countWidth'(robSize));
  // one entry per request, the ack must drop before the next one
  assign accept = dispatchReq_i && !dispatchAck_o && !full && !rob.flushBusy;
  assign dispatchWrites_o = accept && commitPkg::writesReg(dispatchCmd_i);
  assign tailTag_o = tail;

  always_ff @(posedge clk_i or negedge arstN_i) begin
    if (!arstN_i) begin
      head <= '0;
      tail <= '0;
      count <= '0;
      doneMem <= '0;
      dispatchAck_o <= 1'b0;
      dispatchTag_o <= '0;
    end else begin
      if (accept) begin
        tail <= nextPtr(tail);
        dispatchTag_o <= tail;
        dispatchAck_o <= 1'b1;
      end else if (dispatchAck_o && !dispatchReq_i) begin
        dispatchAck_o <= 1'b0;
      end
      if (rob.retire) begin
        head <= nextPtr(head);
      end
      count <= count + countWidth'(accept) - countWidth'(rob.retire);
      if (completeValid_i) begin
        doneMem[completeTag_i] <= 1'b1;
      end
      if (accept) begin
        doneMem[tail] <= 1'b0;
      end
      // flush empties everything, new tags restart at entry 0
      if (rob.flushDone) begin
        head <= '0;
        tail <= '0;
        count <= '0;
        doneMem <= '0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      cmdMem[tail] <= dispatchCmd_i;
      destMem[tail] <= dispatchDest_i;
    end
    if (completeValid_i) begin
      flagValidMem[completeTag_i] <= completeFlagValid_i;
      flagsMem[completeTag_i] <= completeFlags_i;
      dataMem[completeTag_i] <= completeData_i;
    end
  end

  assign rob.headValid = (count != '0) && doneMem[head];
  assign rob.headTag = head;
  assign rob.headCmd = cmdMem[head];
  assign rob.headDest = destMem[head];
  assign rob.headFlagValid = flagValidMem[head];
  assign rob.headFlags = flagsMem[head];
  assign rob.headData = dataMem[head];

  noAckWhenFull: assert property (@(posedge clk_i) disable iff (!arstN_i)
    $rose(dispatchAck_o) |-> $past(!full));

  countBounded: assert property (@(posedge clk_i) disable iff (!arstN_i)
    count <= countWidth'(robSize));

endmodule

// ==== source/renameMap.sv ====
`timescale 1ns/1ps

module renameMap #(
  parameter int robSize = 32,
  localparam int tagWidth = $clog2(robSize)
) (
  input  logic                                 clk_i,
  input  logic                                 arstN_i,
  input  logic                                 recordEn_i,
  input  logic [commitPkg::regAddrWidth-1:0]   recordReg_i,
  input  logic [tagWidth-1:0]                  recordTag_i,
  input  logic [commitPkg::regAddrWidth-1:0]   lookupReg_i,
  output logic                                 lookupPending_o,
  output logic [tagWidth-1:0]                  lookupTag_o,
  mapCommitIf.map                              map
);

  logic [commitPkg::regCount-1:0] pending;
  logic [tagWidth-1:0] tagMem [commitPkg::regCount];
  logic releaseHit;

  assign lookupPending_o = pending[lookupReg_i];
  assign lookupTag_o = tagMem[lookupReg_i];

  assign map.readPending = pending[map.readReg];
  assign map.readTag = tagMem[map.readReg];

  // a younger producer may have taken over the register
  assign releaseHit = map.releaseEn && pending[map.readReg] &&
                      (tagMem[map.readReg] == map.releaseTag);

  always_ff @(posedge clk_i or negedge arstN_i) begin
    if (!arstN_i) begin
      pending <= '0;
    end else if (map.flushAll) begin
      pending <= '0;
    end else begin
      if (releaseHit) begin
        pending[map.readReg] <= 1'b0;
      end
      // a new record wins over a release of the same register
      if (recordEn_i) begin
        pending[recordReg_i] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (recordEn_i) begin
      tagMem[recordReg_i] <= recordTag_i;
    end
  end

endmodule

// ==== source/registerFile.sv ====
`timescale 1ns/1ps

module registerFile (
  input logic clk_i,
  input logic arstN_i,
  regPortIf.rf rf
);

  logic [commitPkg::dataWidth-1:0] regs [commitPkg::regCount];

  // architectural state, cleared on reset
  always_ff @(posedge clk_i or negedge arstN_i) begin
    if (!arstN_i) begin
      for (int i = 0; i < commitPkg::regCount; i++) begin
        regs[i] <= '0;
      end
    end else if (rf.writeEn) begin
      regs[rf.writeAddr] <= rf.writeData;
    end
  end

  // read sees the value before this cycle's write
  assign rf.readData = regs[rf.readAddr];

endmodule

// ==== source/conditionUnit.sv ====
`timescale 1ns/1ps

module conditionUnit (
  input  logic                                clk_i,
  input  logic                                arstN_i,
  input  logic                                flagEn_i,
  input  logic [commitPkg::flagWidth-1:0]     flags_i,
  input  logic [commitPkg::regAddrWidth-1:0]  cond_i,
  output logic                                taken_o
);

  logic [commitPkg::flagWidth-1:0] flags;
  logic negative;
  logic zero;
  logic overflow;
  logic signMismatch;

  // committed NZVC
  always_ff @(posedge clk_i or negedge arstN_i) begin
    if (!arstN_i) begin
      flags <= '0;
    end else if (flagEn_i) begin
      flags <= flags_i;
    end
  end

  assign negative = flags[commitPkg::flagN];
  assign zero = flags[commitPkg::flagZ];
  assign overflow = flags[commitPkg::flagV];
  // signed less-than
  assign signMismatch = negative ^ overflow;

  always_comb begin
    case (cond_i)
      commitPkg::condEq: taken_o = zero;
      commitPkg::condNe: taken_o = !zero;
      commitPkg::condGe: taken_o = !signMismatch;
      commitPkg::condLt: taken_o = signMismatch;
      commitPkg::condGt: taken_o = !zero && !signMismatch;
      // LE
      default: taken_o = zero || signMismatch;
    endcase
  end

endmodule

// ==== source/commitStage.sv ====
`timescale 1ns/1ps

module commitStage #(
  parameter int robSize = 32,
  localparam int tagWidth = $clog2(robSize)
) (
  input  logic                                clk_i,
  input  logic                                arstN_i,
  robCommitIf.commit                          rob,
  mapCommitIf.commit                          map,
  regPortIf.commit                            rf,
  output logic                                flagEn_o,
  output logic [commitPkg::flagWidth-1:0]     flags_o,
  output logic [commitPkg::regAddrWidth-1:0]  cond_o,
  input  logic                                taken_i,
  output logic                                commitValid_o,
  output logic [commitPkg::cmdWidth-1:0]      commitCmd_o,
  output logic                                flushReq_o,
  output logic [commitPkg::dataWidth-1:0]     restorePoint_o,
  input  logic                                flushAck_i
);

  // flush handshake states
  localparam logic [1:0] stIdle = 2'd0;
  localparam logic [1:0] stRequest = 2'd1;
  localparam logic [1:0] stAckLow = 2'd2;

  logic [1:0] state;
  logic [tagWidth-1:0] headTag;
  logic mispredict;
  logic [commitPkg::dataWidth-1:0] restoreNext;
  logic retire;
  logic regWrite;
  logic flushDone;

  assign headTag = rob.headTag;

  // CBZ and BR test the register named by the destination field
  assign rf.readAddr = rob.headDest.regIdx;
  assign map.readReg = rob.headDest.regIdx;
  assign cond_o = rob.headDest.cond;

  always_comb begin
    mispredict = 1'b0;
    restoreNext = rob.headData;
    case (rob.headCmd)
      commitPkg::cmdBcondNot, commitPkg::cmdBcondTaken: begin
        mispredict = (taken_i != rob.headCmd[0]);
      end
      commitPkg::cmdCbzNot: mispredict = (rf.readData == '0);
      commitPkg::cmdCbzTaken: mispredict = (rf.readData != '0);
      commitPkg::cmdBr: begin
        // indirect target comes from the register
        mispredict = (rf.readData != rob.headData);
        restoreNext = rf.readData;
      end
      default: mispredict = 1'b0;
    endcase
  end

  assign retire = rob.headValid && (state == stIdle) && !mispredict;
  assign regWrite = retire && commitPkg::writesReg(rob.headCmd);

  assign rob.retire = retire;
  assign commitValid_o = retire;
  assign commitCmd_o = rob.headCmd;

  assign rf.writeEn = regWrite;
  assign rf.writeAddr = rob.headDest.regIdx;
  assign rf.writeData = rob.headData;

  // release only while the map still names this entry as the producer
  assign map.releaseEn = regWrite && map.readPending && (map.readTag == headTag);
  assign map.releaseTag = headTag;

  assign flagEn_o = retire && rob.headFlagValid;
  assign flags_o = rob.headFlags;

  assign flushDone = (state == stRequest) && flushAck_i;
  assign rob.flushDone = flushDone;
  assign map.flushAll = flushDone;
  assign rob.flushBusy = (state != stIdle);
  assign flushReq_o = (state == stRequest);

  always_ff @(posedge clk_i or negedge arstN_i) begin
    if (!arstN_i) begin
      state <= stIdle;
    end else begin
      case (state)
        stIdle: if (rob.headValid && mispredict) state <= stRequest;
        stRequest: if (flushAck_i) state <= stAckLow;
        stAckLow: if (!flushAck_i) state <= stIdle;
        default: state <= stIdle;
      endcase
    end
  end

  // captured with the request and held until the ack
  always_ff @(posedge clk_i) begin
    if ((state == stIdle) && rob.headValid && mispredict) begin
      restorePoint_o <= restoreNext;
    end
  end

  reqHeldUntilAck: assert property (@(posedge clk_i) disable iff (!arstN_i)
    $fell(flushReq_o) |-> $past(flushAck_i));

endmodule

// ==== source/commitSubsystem.sv ====
`timescale 1ns/1ps

module commitSubsystem #(
  parameter int robSize = 32,
  localparam int tagWidth = $clog2(robSize)
) (
  input  logic                                clk_i,
  input  logic                                arstN_i,
  // dispatch
  input  logic                                dispatchReq_i,
  input  logic [commitPkg::cmdWidth-1:0]      dispatchCmd_i,
  input  commitPkg::robDest_u                 dispatchDest_i,
  output logic                                dispatchAck_o,
  output logic [tagWidth-1:0]                 dispatchTag_o,
  // completion
  input  logic                                completeValid_i,
  input  logic [tagWidth-1:0]                 completeTag_i,
  input  logic                                completeFlagValid_i,
  input  logic [commitPkg::flagWidth-1:0]     completeFlags_i,
  input  logic [commitPkg::dataWidth-1:0]     completeData_i,
  // rename lookup
  input  logic [commitPkg::regAddrWidth-1:0]  renameReg_i,
  output logic                                renamePending_o,
  output logic [tagWidth-1:0]                 renameTag_o,
  // retirement
  output logic                                commitValid_o,
  output logic [commitPkg::cmdWidth-1:0]      commitCmd_o,
  output logic                                regWrite_o,
  output logic [commitPkg::regAddrWidth-1:0]  writeRegister_o,
  output logic [commitPkg::dataWidth-1:0]     writeData_o,
  // flush
  output logic                                flushReq_o,
  output logic [commitPkg::dataWidth-1:0]     restorePoint_o,
  input  logic                                flushAck_i
);

  robCommitIf #(.robSize(robSize)) robBus ();
  mapCommitIf #(.robSize(robSize)) mapBus ();
  regPortIf regBus ();

  logic recordEn;
  logic [tagWidth-1:0] tailTag;
  logic flagEn;
  logic [commitPkg::flagWidth-1:0] commitFlags;
  logic [commitPkg::regAddrWidth-1:0] branchCond;
  logic branchTaken;

  reorderBuffer #(.robSize(robSize)) u_rob (
    .clk_i, .arstN_i,
    .dispatchReq_i, .dispatchCmd_i, .dispatchDest_i, .dispatchAck_o, .dispatchTag_o,
    .tailTag_o(tailTag), .dispatchWrites_o(recordEn),
    .completeValid_i, .completeTag_i, .completeFlagValid_i, .completeFlags_i, .completeData_i,
    .rob(robBus.rob)
  );

  // map records the tail tag at the dispatch edge
  renameMap #(.robSize(robSize)) u_map (
    .clk_i, .arstN_i,
    .recordEn_i(recordEn), .recordReg_i(dispatchDest_i.regIdx), .recordTag_i(tailTag),
    .lookupReg_i(renameReg_i), .lookupPending_o(renamePending_o), .lookupTag_o(renameTag_o),
    .map(mapBus.map)
  );

  registerFile u_regs (.clk_i, .arstN_i, .rf(regBus.rf));

  conditionUnit u_cond (
    .clk_i, .arstN_i,
    .flagEn_i(flagEn), .flags_i(commitFlags), .cond_i(branchCond), .taken_o(branchTaken)
  );

  commitStage #(.robSize(robSize)) u_commit (
    .clk_i, .arstN_i,
    .rob(robBus.commit), .map(mapBus.commit), .rf(regBus.commit),
    .flagEn_o(flagEn), .flags_o(commitFlags), .cond_o(branchCond), .taken_i(branchTaken),
    .commitValid_o, .commitCmd_o, .flushReq_o, .restorePoint_o, .flushAck_i
  );

  assign regWrite_o = regBus.writeEn;
  assign writeRegister_o = regBus.writeAddr;
  assign writeData_o = regBus.writeData;

endmodule

// ==== testbench/tbClock.sv ====
`timescale 1ns/1ps

module tbClock (
  output logic clk_o,
  output logic arstN_o
);

  // 4 ns period
  initial clk_o = 1'b0;
  always #2 clk_o = ~clk_o;

  // reset held for three rising edges, released on a falling edge
  initial begin
    arstN_o = 1'b0;
    repeat (3) @(posedge clk_o);
    @(negedge clk_o);
    arstN_o = 1'b1;
  end

endmodule

// ==== testbench/tbChecker.sv ====
`timescale 1ns/1ps

module tbChecker #(
  parameter int robSize = 8,
  localparam int tagWidth = $clog2(robSize)
) (
  input  logic                                clk_i,
  input  logic                                arstN_i,
  input  logic                                dispatchReq_i,
  input  logic [commitPkg::cmdWidth-1:0]      dispatchCmd_i,
  input  logic [commitPkg::regAddrWidth-1:0]  dispatchDest_i,
  input  logic                                dispatchAck_i,
  input  logic [tagWidth-1:0]                 dispatchTag_i,
  input  logic                                completeValid_i,
  input  logic [tagWidth-1:0]                 completeTag_i,
  input  logic                                completeFlagValid_i,
  input  logic [commitPkg::flagWidth-1:0]     completeFlags_i,
  input  logic [commitPkg::dataWidth-1:0]     completeData_i,
  input  logic [commitPkg::regAddrWidth-1:0]  renameReg_i,
  input  logic                                renamePending_i,
  input  logic [tagWidth-1:0]                 renameTag_i,
  input  logic                                commitValid_i,
  input  logic [commitPkg::cmdWidth-1:0]      commitCmd_i,
  input  logic                                regWrite_i,
  input  logic [commitPkg::regAddrWidth-1:0]  writeRegister_i,
  input  logic [commitPkg::dataWidth-1:0]     writeData_i,
  input  logic                                flushReq_i,
  input  logic [commitPkg::dataWidth-1:0]     restorePoint_i,
  input  logic                                flushAck_i,
  output int                                  errors_o,
  output int                                  checks_o,
  output logic                                idle_o
);

  // model buffer, indexed by tag
  logic [commitPkg::cmdWidth-1:0] cmdQ [robSize];
  logic [commitPkg::regAddrWidth-1:0] destQ [robSize];
  logic doneQ [robSize];
  logic [commitPkg::dataWidth-1:0] dataQ [robSize];
  logic flagValidQ [robSize];
  logic [commitPkg::flagWidth-1:0] flagsQ [robSize];
  int head;
  int tail;
  int count;

  // architectural model
  logic [commitPkg::dataWidth-1:0] regModel [commitPkg::regCount];
  logic pendModel [commitPkg::regCount];
  logic [tagWidth-1:0] tagModel [commitPkg::regCount];
  logic [commitPkg::flagWidth-1:0] flagModel;

  // 0 idle, 1 request out, 2 waiting for the ack to drop
  int flushState;
  logic [commitPkg::dataWidth-1:0] restoreModel;
  logic ackModel;
  logic [tagWidth-1:0] tagOutModel;

  assign idle_o = (count == 0) && (flushState == 0);

  task automatic compareValue(input string what, input logic [63:0] got,
                              input logic [63:0] exp);
    checks_o++;
    if (got !== exp) begin
      errors_o++;
      $display("ERROR %0t: %s is %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  // branch condition from committed NZVC
  function automatic logic condTaken(input logic [4:0] cond, input logic [3:0] f);
    logic n;
    logic z;
    logic v;
    n = f[commitPkg::flagN];
    z = f[commitPkg::flagZ];
    v = f[commitPkg::flagV];
    case (cond)
      commitPkg::condEq: return z;
      commitPkg::condNe: return !z;
      commitPkg::condGe: return n == v;
      commitPkg::condLt: return n != v;
      commitPkg::condGt: return !z && (n == v);
      default: return z || (n != v);
    endcase
  endfunction

  always @(posedge clk_i or negedge arstN_i) begin : modelStep
    logic headValid;
    logic mispredict;
    logic retire;
    logic accept;
    logic writes;
    logic [commitPkg::dataWidth-1:0] restore;
    logic [commitPkg::dataWidth-1:0] regValue;
    logic [commitPkg::cmdWidth-1:0] hCmd;
    logic [commitPkg::regAddrWidth-1:0] hDest;
    if (!arstN_i) begin
      head = 0;
      tail = 0;
      count = 0;
      for (int i = 0; i < robSize; i++) begin
        doneQ[i] = 1'b0;
      end
      for (int r = 0; r < commitPkg::regCount; r++) begin
        regModel[r] = '0;
        pendModel[r] = 1'b0;
        tagModel[r] = '0;
      end
      flagModel = '0;
      flushState = 0;
      restoreModel = '0;
      ackModel = 1'b0;
      tagOutModel = '0;
      errors_o = 0;
      checks_o = 0;
    end else begin
      hCmd = cmdQ[head];
      hDest = destQ[head];
      regValue = regModel[hDest];
      headValid = (count > 0) && doneQ[head];
      mispredict = 1'b0;
      restore = dataQ[head];
      if (headValid) begin
        case (hCmd)
          commitPkg::cmdBcondNot, commitPkg::cmdBcondTaken:
            mispredict = condTaken(hDest, flagModel) != hCmd[0];
          commitPkg::cmdCbzNot: mispredict = (regValue == 0);
          commitPkg::cmdCbzTaken: mispredict = (regValue != 0);
          commitPkg::cmdBr: begin
            mispredict = (regValue != dataQ[head]);
            restore = regValue;
          end
          default: mispredict = 1'b0;
        endcase
      end
      retire = headValid && (flushState == 0) && !mispredict;
      writes = (hCmd == commitPkg::cmdAlu) || (hCmd == commitPkg::cmdBl);

      // outputs seen in this cycle
      compareValue("commitValid_o", commitValid_i, retire);
      if (retire) begin
        compareValue("commitCmd_o", commitCmd_i, hCmd);
        compareValue("regWrite_o", regWrite_i, writes);
        if (writes) begin
          compareValue("writeRegister_o", writeRegister_i, hDest);
          compareValue("writeData_o", writeData_i, dataQ[head]);
        end
      end else begin
        compareValue("regWrite_o", regWrite_i, 1'b0);
      end
      compareValue("flushReq_o", flushReq_i, flushState == 1);
      if (flushState == 1) begin
        compareValue("restorePoint_o", restorePoint_i, restoreModel);
      end
      compareValue("dispatchAck_o", dispatchAck_i, ackModel);
      if (ackModel) begin
        compareValue("dispatchTag_o", dispatchTag_i, tagOutModel);
      end
      compareValue("renamePending_o", renamePending_i, pendModel[renameReg_i]);
      if (pendModel[renameReg_i]) begin
        compareValue("renameTag_o", renameTag_i, tagModel[renameReg_i]);
      end

      // state after this edge
      accept = dispatchReq_i && !ackModel && (count < robSize) && (flushState == 0);
      if (accept) begin
        ackModel = 1'b1;
        tagOutModel = tagWidth'(tail);
      end else if (ackModel && !dispatchReq_i) begin
        ackModel = 1'b0;
      end
      if (completeValid_i) begin
        doneQ[completeTag_i] = 1'b1;
        dataQ[completeTag_i] = completeData_i;
        flagValidQ[completeTag_i] = completeFlagValid_i;
        flagsQ[completeTag_i] = completeFlags_i;
      end
      if (retire) begin
        if (writes) begin
          regModel[hDest] = dataQ[head];
          // release only if no younger writer took the register
          if (pendModel[hDest] && (tagModel[hDest] == tagWidth'(head))) begin
            pendModel[hDest] = 1'b0;
          end
        end
        if (flagValidQ[head]) begin
          flagModel = flagsQ[head];
        end
        head = (head + 1) % robSize;
        count--;
      end
      if (accept) begin
        cmdQ[tail] = dispatchCmd_i;
        destQ[tail] = dispatchDest_i;
        doneQ[tail] = 1'b0;
        if ((dispatchCmd_i == commitPkg::cmdAlu) || (dispatchCmd_i == commitPkg::cmdBl)) begin
          pendModel[dispatchDest_i] = 1'b1;
          tagModel[dispatchDest_i] = tagWidth'(tail);
        end
        tail = (tail + 1) % robSize;
        count++;
      end
      case (flushState)
        0: begin
          if (headValid && mispredict) begin
            flushState = 1;
            restoreModel = restore;
          end
        end
        1: begin
          if (flushAck_i) begin
            head = 0;
            tail = 0;
            count = 0;
            for (int i = 0; i < robSize; i++) begin
              doneQ[i] = 1'b0;
            end
            for (int r = 0; r < commitPkg::regCount; r++) begin
              pendModel[r] = 1'b0;
            end
            flushState = 2;
          end
        end
        default: begin
          if (!flushAck_i) flushState = 0;
        end
      endcase
    end
  end

endmodule

// ==== testbench/tbTop.sv ====
`timescale 1ns/1ps

module tbTop;

  localparam int robSize = 8;
  localparam int tagWidth = $clog2(robSize);
  localparam int dispatchTotal = 300;
  localparam int cycleLimit = dispatchTotal * 40;

  logic clk;
  logic arstN;
  logic dispatchReq;
  logic [commitPkg::cmdWidth-1:0] dispatchCmd;
  logic [commitPkg::regAddrWidth-1:0] dispatchDest;
  logic dispatchAck;
  logic [tagWidth-1:0] dispatchTag;
  logic completeValid;
  logic [tagWidth-1:0] completeTag;
  logic completeFlagValid;
  logic [commitPkg::flagWidth-1:0] completeFlags;
  logic [commitPkg::dataWidth-1:0] completeData;
  logic [commitPkg::regAddrWidth-1:0] renameReg;
  logic renamePending;
  logic [tagWidth-1:0] renameTag;
  logic commitValid;
  logic [commitPkg::cmdWidth-1:0] commitCmd;
  logic regWrite;
  logic [commitPkg::regAddrWidth-1:0] writeRegister;
  logic [commitPkg::dataWidth-1:0] writeData;
  logic flushReq;
  logic [commitPkg::dataWidth-1:0] restorePoint;
  logic flushAck;
  int errors;
  int checks;
  logic modelIdle;

  // stimulus state
  logic [31:0] rngState;
  logic [tagWidth-1:0] inflightTag [$];
  logic [commitPkg::cmdWidth-1:0] inflightCmd [$];
  logic [commitPkg::regAddrWidth-1:0] inflightDest [$];
  int dispatched;
  int ackWait;
  int cycles;
  logic timedOut;
  logic finished;

  tbClock u_clock (.clk_o(clk), .arstN_o(arstN));

  commitSubsystem #(.robSize(robSize)) u_dut (
    .clk_i(clk), .arstN_i(arstN),
    .dispatchReq_i(dispatchReq), .dispatchCmd_i(dispatchCmd), .dispatchDest_i(dispatchDest),
    .dispatchAck_o(dispatchAck), .dispatchTag_o(dispatchTag),
    .completeValid_i(completeValid), .completeTag_i(completeTag),
    .completeFlagValid_i(completeFlagValid), .completeFlags_i(completeFlags),
    .completeData_i(completeData),
    .renameReg_i(renameReg), .renamePending_o(renamePending), .renameTag_o(renameTag),
    .commitValid_o(commitValid), .commitCmd_o(commitCmd), .regWrite_o(regWrite),
    .writeRegister_o(writeRegister), .writeData_o(writeData),
    .flushReq_o(flushReq), .restorePoint_o(restorePoint), .flushAck_i(flushAck)
  );

  tbChecker #(.robSize(robSize)) u_check (
    .clk_i(clk), .arstN_i(arstN),
    .dispatchReq_i(dispatchReq), .dispatchCmd_i(dispatchCmd), .dispatchDest_i(dispatchDest),
    .dispatchAck_i(dispatchAck), .dispatchTag_i(dispatchTag),
    .completeValid_i(completeValid), .completeTag_i(completeTag),
    .completeFlagValid_i(completeFlagValid), .completeFlags_i(completeFlags),
    .completeData_i(completeData),
    .renameReg_i(renameReg), .renamePending_i(renamePending), .renameTag_i(renameTag),
    .commitValid_i(commitValid), .commitCmd_i(commitCmd), .regWrite_i(regWrite),
    .writeRegister_i(writeRegister), .writeData_i(writeData),
    .flushReq_i(flushReq), .restorePoint_i(restorePoint), .flushAck_i(flushAck),
    .errors_o(errors), .checks_o(checks), .idle_o(modelIdle)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  function automatic logic [31:0] nextRandom();
    rngState = xorshift(rngState);
    return rngState;
  endfunction

  function automatic int randomBelow(input int n);
    return int'(nextRandom() % 32'(n));
  endfunction

  // few registers so that writers collide in the map
  task automatic driveDispatch();
    if (dispatchReq && dispatchAck) begin
      inflightTag.push_back(dispatchTag);
      inflightCmd.push_back(dispatchCmd);
      inflightDest.push_back(dispatchDest);
      dispatched++;
      dispatchReq = 1'b0;
    end else if (!dispatchReq && !dispatchAck && dispatched < dispatchTotal &&
                 randomBelow(4) != 0) begin
      dispatchCmd = (randomBelow(16) < 6) ? commitPkg::cmdAlu : 3'(randomBelow(8));
      dispatchDest = 5'(randomBelow(8));
      if (dispatchCmd == commitPkg::cmdBcondNot || dispatchCmd == commitPkg::cmdBcondTaken) begin
        case (randomBelow(6))
          0: dispatchDest = commitPkg::condEq;
          1: dispatchDest = commitPkg::condNe;
          2: dispatchDest = commitPkg::condGe;
          3: dispatchDest = commitPkg::condLt;
          4: dispatchDest = commitPkg::condGt;
          default: dispatchDest = 5'(randomBelow(32));
        endcase
      end
      dispatchReq = 1'b1;
    end
  endtask

  task automatic answerFlush();
    if (flushAck && !flushReq) begin
      flushAck = 1'b0;
    end else if (flushReq && !flushAck) begin
      if (ackWait < 0) ackWait = randomBelow(4);
      if (ackWait == 0) begin
        flushAck = 1'b1;
        ackWait = -1;
        // everything in flight is discarded by the flush
        inflightTag.delete();
        inflightCmd.delete();
        inflightDest.delete();
      end else begin
        ackWait--;
      end
    end
  endtask

  task automatic sendCompletion();
    int idx;
    int odds;
    logic [commitPkg::cmdWidth-1:0] cmd;
    logic [commitPkg::regAddrWidth-1:0] dest;
    completeValid = 1'b0;
    // results trickle in for part of the time so the buffer fills up
    odds = ((cycles % 200) < 60) ? 12 : 2;
    if (!flushReq && !flushAck && inflightTag.size() > 0 && randomBelow(odds) == 0) begin
      idx = randomBelow(inflightTag.size());
      cmd = inflightCmd[idx];
      dest = inflightDest[idx];
      completeTag = inflightTag[idx];
      inflightTag.delete(idx);
      inflightCmd.delete(idx);
      inflightDest.delete(idx);
      completeData = {nextRandom(), nextRandom()};
      // zero results give CBZ both outcomes, matching targets give BR both
      if (cmd == commitPkg::cmdAlu && randomBelow(3) == 0) completeData = '0;
      if (cmd == commitPkg::cmdBr && randomBelow(2) == 0) begin
        completeData = u_check.regModel[dest];
      end
      completeFlagValid = randomBelow(2) == 0;
      completeFlags = 4'(nextRandom());
      completeValid = 1'b1;
    end
  endtask

  initial begin
    dispatchReq = 1'b0;
    dispatchCmd = '0;
    dispatchDest = '0;
    completeValid = 1'b0;
    completeTag = '0;
    completeFlagValid = 1'b0;
    completeFlags = '0;
    completeData = '0;
    renameReg = '0;
    flushAck = 1'b0;
    rngState = 32'h5af7;
    dispatched = 0;
    ackWait = -1;
    cycles = 0;
    timedOut = 1'b0;
    finished = 1'b0;
    @(posedge arstN);
    while (!finished && !timedOut) begin
      @(negedge clk);
      cycles++;
      if (cycles > cycleLimit) begin
        timedOut = 1'b1;
      end else begin
        driveDispatch();
        answerFlush();
        sendCompletion();
        renameReg = (randomBelow(2) == 0) ? 5'(randomBelow(8)) : 5'(randomBelow(32));
        finished = (dispatched >= dispatchTotal) && (inflightTag.size() == 0) &&
                   !dispatchReq && !flushAck && modelIdle;
      end
    end
    @(negedge clk);
    if (timedOut) begin
      $display("hang: the run did not drain within %0d cycles", cycleLimit);
    end
    $display("dispatches %0d, checks %0d, errors %0d", dispatched, checks, errors);
    if (timedOut || errors != 0) begin
      $display("SOME TESTS FAILED");
    end else begin
      $display("ALL TESTS PASSED");
    end
    $finish;
  end

endmodule

// ==== tb.f ====
source/commitPkg.sv
source/commitIfs.sv
source/reorderBuffer.sv
source/renameMap.sv
source/registerFile.sv
source/conditionUnit.sv
source/commitStage.sv
source/commitSubsystem.sv
testbench/tbClock.sv
testbench/tbChecker.sv
testbench/tbTop.sv
